//--- smc_macros.svh
`ifndef SMC_MACROS_SVH
`define SMC_MACROS_SVH

// --------------------
// Bus widths
// --------------------
`define SMC_DATA_W   32     // Wishbone and SRAM data
`define SMC_ADDR_W   16     // SRAM word address
`define SMC_PADDR_W  5      // APB address

// --------------------
// Register map
// --------------------
`define SMC_CFG_ADDR 5'h00  // Timing config register

// Width of one wait-state field in the config register
`define SMC_WAIT_W   4

`endif

//--- smc_pkg.sv
`include "smc_macros.svh"

// --------------------
// Register layout
// --------------------
package smc_reg_pkg;

  // Timing config, enable at the top, fields packed at the bottom
  typedef struct packed {
    logic                   enable;   // Bit 31
    logic [20:0]            rsvd;     // Read as zero
    logic [1:0]             turn;     // Turnaround cycles after ack
    logic [`SMC_WAIT_W-1:0] wr_wait;  // Extra write strobe cycles
    logic [`SMC_WAIT_W-1:0] rd_wait;  // Extra read strobe cycles
  } smc_cfg_t;

endpackage

// --------------------
// Memory cycle types
// --------------------
package smc_mem_pkg;

  typedef enum logic [2:0] {
    IDLE,    // Waiting for a Wishbone request
    SETUP,   // Chip select and address out
    STROBE,  // oe_n or we_n low
    ACK,     // Single-cycle ack
    ERR,     // Access while disabled
    TURN     // Bus turnaround gap
  } smc_state_e;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } smc_op_e;

endpackage

//--- smc_intf.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

// Strobe and capture controls from FSM to datapath
interface smc_strobe_if;
  import smc_mem_pkg::*;

  logic    latch;    // Grab address, data, selects
  smc_op_e op;       // Direction of the current access
  logic    cs;
  logic    oe;
  logic    we;
  logic    capture;  // Grab mem_dq_in

  modport fsm (output latch, op, cs, oe, we, capture);
  modport dp  (input  latch, op, cs, oe, we, capture);
endinterface

// Wait-state counter handshake
interface smc_timer_if;
  logic                   load;
  logic [`SMC_WAIT_W-1:0] count;  // Start value
  logic                   done;   // Counter at zero

  modport ctrl  (output load, count, input  done);
  modport timer (input  load, count, output done);
endinterface

//--- smc_apb_if.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

// APB-lite access to the timing config register
module smc_apb_if (
  input  logic                    pclk,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`SMC_PADDR_W-1:0] paddr,
  input  logic [`SMC_DATA_W-1:0]  pwdata,
  output logic [`SMC_DATA_W-1:0]  prdata,
  output smc_reg_pkg::smc_cfg_t   cfg
);
  import smc_reg_pkg::*;

  logic     sel_reg;  // Config register selected in access phase
  logic     cfg_wr;
  smc_cfg_t cfg_d;    // Write data with reserved bits cleared
  smc_cfg_t cfg_q;

  // --------------------
  // Address decode
  // --------------------
  always_comb
  begin
    if (psel && penable)
      sel_reg = (paddr == `SMC_CFG_ADDR);
    else
      sel_reg = 1'b0;
  end

  assign cfg_wr = sel_reg && pwrite;  // No wait states on this bus

  always_comb
  begin
    cfg_d      = smc_cfg_t'(pwdata);
    cfg_d.rsvd = '0;                  // Reserved reads back zero
  end

  // --------------------
  // Config register
  // --------------------
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
      cfg_q <= '0;                    // Comes up disabled
    else if (cfg_wr)
      cfg_q <= cfg_d;
  end

  assign cfg = cfg_q;

  // Read-back, zero for unmapped addresses
  assign prdata = (paddr == `SMC_CFG_ADDR) ? cfg_q : '0;

endmodule

//--- smc_wait_timer.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

// Down-counter for strobe and turnaround lengths
module smc_wait_timer (
  input logic        pclk,
  input logic        rst_n,
  smc_timer_if.timer tmr
);

  logic [`SMC_WAIT_W-1:0] cnt_q;

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else if (tmr.load)
      cnt_q <= tmr.count;       // Reload wins over decrement
    else if (cnt_q != '0)
      cnt_q <= cnt_q - 1'b1;    // Sticks at zero
  end

  // Zero means the current phase ends this cycle
  assign tmr.done = (cnt_q == '0);

endmodule

//--- smc_fsm.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

// Memory cycle sequencer
module smc_fsm (
  input  logic                  pclk,
  input  logic                  rst_n,
  input  smc_reg_pkg::smc_cfg_t cfg,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  output logic                  wb_ack,
  output logic                  wb_err,
  smc_strobe_if.fsm             stb,
  smc_timer_if.ctrl             tmr
);
  import smc_reg_pkg::*;
  import smc_mem_pkg::*;

  smc_state_e             state, state_d;
  smc_op_e                op_q, op_d;
  smc_cfg_t               cfg_q;       // Timing frozen per access
  logic                   req;
  logic                   latch;
  logic [`SMC_WAIT_W-1:0] wait_sel;    // rd_wait or wr_wait
  logic [`SMC_WAIT_W-1:0] turn_cnt;
  logic                   cs_q, oe_q, we_q;

  assign req   = wb_cyc && wb_stb;
  assign latch = (state == IDLE) && req && cfg.enable;
  assign op_d  = latch ? (wb_we ? OP_WRITE : OP_READ) : op_q;

  // --------------------
  // Next state
  // --------------------
  always_comb
  begin
    state_d = state;
    case (state)
      IDLE:    if (req) state_d = cfg.enable ? SETUP : ERR;
      SETUP:   state_d = STROBE;
      STROBE:  if (tmr.done) state_d = ACK;
      ACK:     state_d = (cfg_q.turn != 2'd0) ? TURN : IDLE;
      ERR:     state_d = IDLE;
      TURN:    if (tmr.done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      op_q  <= OP_READ;
      cs_q  <= 1'b0;
      oe_q  <= 1'b0;
      we_q  <= 1'b0;
    end
    else
    begin
      state <= state_d;
      op_q  <= op_d;
      cs_q  <= (state_d == SETUP) || (state_d == STROBE);
      oe_q  <= (state_d == STROBE) && (op_d == OP_READ);
      we_q  <= (state_d == STROBE) && (op_d == OP_WRITE);
    end
  end

  // Snapshot so APB writes mid-access do not disturb it
  always_ff @(posedge pclk)
  begin
    if (latch)
      cfg_q <= cfg;
  end

  // --------------------
  // Timer control
  // --------------------
  assign wait_sel  = (op_q == OP_WRITE) ? cfg_q.wr_wait : cfg_q.rd_wait;
  assign turn_cnt  = cfg_q.turn - 1'b1;                  // TURN lasts turn cycles
  assign tmr.load  = (state == SETUP) || ((state == ACK) && (cfg_q.turn != 2'd0));
  assign tmr.count = (state == SETUP) ? wait_sel : turn_cnt;

  // Outputs to datapath
  assign stb.latch   = latch;
  assign stb.op      = op_q;
  assign stb.cs      = cs_q;
  assign stb.oe      = oe_q;
  assign stb.we      = we_q;
  assign stb.capture = (state == STROBE) && tmr.done && (op_q == OP_READ);  // Last strobe cycle

  assign wb_ack = (state == ACK);
  assign wb_err = (state == ERR);

endmodule

//--- smc_datapath.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

// Address, data and byte-select registers plus SRAM pin drive
module smc_datapath (
  input  logic                     pclk,
  input  logic                     rst_n,
  input  logic [`SMC_ADDR_W-1:0]   wb_adr,
  input  logic [`SMC_DATA_W/8-1:0] wb_sel,
  input  logic [`SMC_DATA_W-1:0]   wb_dat_w,
  input  logic [`SMC_DATA_W-1:0]   mem_dq_in,
  output logic [`SMC_DATA_W-1:0]   wb_dat_r,
  output logic [`SMC_ADDR_W-1:0]   mem_addr,
  output logic [`SMC_DATA_W/8-1:0] mem_be_n,
  output logic [`SMC_DATA_W-1:0]   mem_dq_out,
  output logic                     mem_dq_oe,
  output logic                     mem_cs_n,
  output logic                     mem_oe_n,
  output logic                     mem_we_n,
  smc_strobe_if.dp                 stb
);
  import smc_mem_pkg::*;

  logic [`SMC_ADDR_W-1:0]   addr_q;
  logic [`SMC_DATA_W/8-1:0] sel_q;
  logic [`SMC_DATA_W-1:0]   wdat_q;
  logic [`SMC_DATA_W-1:0]   rdat_q;

  // Byte lanes idle high out of reset
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
      sel_q <= '0;
    else if (stb.latch)
      sel_q <= wb_sel;
  end

  always_ff @(posedge pclk)
  begin
    if (stb.latch)
    begin
      addr_q <= wb_adr;
      wdat_q <= wb_dat_w;
    end
    if (stb.capture)
      rdat_q <= mem_dq_in;  // Sampled while oe_n still low
  end

  // --------------------
  // SRAM pins
  // --------------------
  assign mem_addr   = addr_q;
  assign mem_be_n   = ~sel_q;
  assign mem_dq_out = wdat_q;
  assign mem_dq_oe  = stb.cs && (stb.op == OP_WRITE);  // Drive through setup and strobe
  assign mem_cs_n   = ~stb.cs;
  assign mem_oe_n   = ~stb.oe;
  assign mem_we_n   = ~stb.we;

  assign wb_dat_r = rdat_q;

endmodule

//--- smc_top.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

// Static memory controller top
module smc_top (
  input  logic                     pclk,
  input  logic                     rst_n,
  // APB config port
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`SMC_PADDR_W-1:0]  paddr,
  input  logic [`SMC_DATA_W-1:0]   pwdata,
  output logic [`SMC_DATA_W-1:0]   prdata,
  // Wishbone classic slave
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`SMC_ADDR_W-1:0]   wb_adr,    // Word address
  input  logic [`SMC_DATA_W/8-1:0] wb_sel,
  input  logic [`SMC_DATA_W-1:0]   wb_dat_w,
  output logic [`SMC_DATA_W-1:0]   wb_dat_r,
  output logic                     wb_ack,
  output logic                     wb_err,
  // SRAM
  output logic [`SMC_ADDR_W-1:0]   mem_addr,
  output logic [`SMC_DATA_W/8-1:0] mem_be_n,
  output logic [`SMC_DATA_W-1:0]   mem_dq_out,
  output logic                     mem_dq_oe,
  input  logic [`SMC_DATA_W-1:0]   mem_dq_in,
  output logic                     mem_cs_n,
  output logic                     mem_oe_n,
  output logic                     mem_we_n
);
  import smc_reg_pkg::*;

  smc_cfg_t cfg;  // Live register value

  smc_strobe_if stb_if ();
  smc_timer_if  tmr_if ();

  // --------------------
  // Blocks
  // --------------------
  smc_apb_if u_apb_if (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .cfg (cfg)
  );

  smc_fsm u_fsm (
    .pclk, .rst_n, .cfg, .wb_cyc, .wb_stb, .wb_we, .wb_ack, .wb_err,
    .stb (stb_if.fsm),
    .tmr (tmr_if.ctrl)
  );

  smc_wait_timer u_wait_timer (
    .pclk, .rst_n,
    .tmr (tmr_if.timer)
  );

  smc_datapath u_datapath (
    .pclk, .rst_n, .wb_adr, .wb_sel, .wb_dat_w, .mem_dq_in, .wb_dat_r,
    .mem_addr, .mem_be_n, .mem_dq_out, .mem_dq_oe,
    .mem_cs_n, .mem_oe_n, .mem_we_n,
    .stb (stb_if.dp)
  );

endmodule

//--- smc_checker.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

// Watches the DUT ports and compares with the expected values
module smc_checker (
  input logic                    pclk,
  input logic                    rst_n,
  input logic                    psel,
  input logic                    penable,
  input logic                    pwrite,
  input logic [`SMC_PADDR_W-1:0] paddr,
  input logic [`SMC_DATA_W-1:0]  pwdata,
  input logic [`SMC_DATA_W-1:0]  prdata,
  input logic                    wb_cyc,
  input logic                    wb_stb,
  input logic [`SMC_DATA_W-1:0]  wb_dat_r,
  input logic                    wb_ack,
  input logic                    wb_err,
  input logic                    mem_cs_n,
  input logic                    mem_oe_n,
  input logic                    mem_we_n,
  input logic                    mem_dq_oe
);

  int errors = 0;

  // Expectation for the access in flight
  string                  exp_name;
  logic [`SMC_DATA_W-1:0] exp_data;
  int                     exp_lat;
  bit                     exp_err;
  bit                     exp_read;
  bit                     armed = 0;
  bit                     busy  = 0;
  bit                     strobe_seen;
  int                     cnt;

  // Turnaround tracking
  int       gap = 0;
  bit       had_access = 0;
  bit [1:0] turn_cfg = 0;

  task arm_access(input string name, input bit rd, input logic [31:0] data,
                  input int lat, input bit err);
    exp_name = name;
    exp_read = rd;
    exp_data = data;
    exp_lat  = lat;
    exp_err  = err;
    armed    = 1;
  endtask

  // prdata is combinational and stable in the access phase
  task check_prdata(input string name, input logic [31:0] exp);
    if (prdata !== exp)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, prdata);
      errors++;
    end
  endtask

  // --------------------
  // Wishbone responses
  // --------------------
  always @(posedge pclk)
  begin
    if (!rst_n)
    begin
      busy  = 0;
      armed = 0;
    end
    else if (busy)
    begin
      cnt++;
      if (!mem_cs_n || !mem_oe_n || !mem_we_n)
        strobe_seen = 1;  // Any SRAM strobe
      if (wb_ack || wb_err)
      begin
        busy = 0;
        if (wb_err !== exp_err)  // Wrong kind of response
        begin
          $display("Fail %s: expected err %0d, actual err %0d", exp_name, exp_err, wb_err);
          errors++;
        end
        if (wb_err && strobe_seen)
        begin
          $display("%s: memory strobed on a disabled access", exp_name);
          errors++;
        end
        if (wb_ack && exp_read && (wb_dat_r !== exp_data))
        begin
          $display("Fail %s: expected %h, actual %h", exp_name, exp_data, wb_dat_r);
          errors++;
        end
        // Response edge counted from the sampling edge
        if ((exp_lat >= 0) && (cnt - 1 != exp_lat))
        begin
          $display("Fail %s: expected latency %0d, actual %0d", exp_name, exp_lat, cnt - 1);
          errors++;
        end
      end
    end
    else if (armed && wb_cyc && wb_stb)
    begin
      busy        = 1;  // Sampling edge
      armed       = 0;
      cnt         = 0;
      strobe_seen = 0;
    end
  end

  // --------------------
  // SRAM pin rules
  // --------------------
  always @(posedge pclk)
  begin
    if (rst_n)
    begin
      if (psel && penable && pwrite && (paddr == `SMC_CFG_ADDR))
        turn_cfg = pwdata[9:8];
      if (!mem_we_n && !mem_dq_oe)
      begin
        $display("Write strobe low while the data bus is not driven");
        errors++;
      end
      if (mem_cs_n)
        gap++;
      else
      begin
        if (had_access && (gap > 0) && (gap < turn_cfg))
        begin
          $display("Chip select gap of %0d cycles is shorter than turnaround %0d",
                   gap, turn_cfg);
          errors++;
        end
        gap        = 0;
        had_access = 1;
      end
    end
  end

endmodule

//--- smc_props.sv
`timescale 1ns/100ps

// Protocol assertions on the memory cycle FSM
module smc_props (
  input logic pclk,
  input logic rst_n,
  input logic wb_ack,
  input logic wb_err,
  input logic oe,
  input logic we
);

  int fails = 0;  // Failed assertion count

  a_ack_err_excl: assert property (@(posedge pclk) disable iff (!rst_n)
    !(wb_ack && wb_err))
  else
  begin
    $error("ack and err high together");
    fails++;
  end

  a_ack_one: assert property (@(posedge pclk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
  else
  begin
    $error("ack longer than one cycle");
    fails++;
  end

  a_err_one: assert property (@(posedge pclk) disable iff (!rst_n)
    wb_err |=> !wb_err)
  else
  begin
    $error("err longer than one cycle");
    fails++;
  end

  // oe_n and we_n never both low
  a_strobe_excl: assert property (@(posedge pclk) disable iff (!rst_n)
    !(oe && we))
  else
  begin
    $error("output and write enable together");
    fails++;
  end

endmodule

bind smc_fsm smc_props u_props (
  .pclk (pclk), .rst_n (rst_n), .wb_ack (wb_ack), .wb_err (wb_err),
  .oe (oe_q), .we (we_q)
);

//--- smc_tb.sv
`timescale 1ns/100ps
`include "smc_macros.svh"

module smc_tb;

  logic                     pclk = 0;
  logic                     rst_n;
  logic                     psel, penable, pwrite;
  logic [`SMC_PADDR_W-1:0]  paddr;
  logic [`SMC_DATA_W-1:0]   pwdata, prdata;
  logic                     wb_cyc, wb_stb, wb_we;
  logic [`SMC_ADDR_W-1:0]   wb_adr;
  logic [`SMC_DATA_W/8-1:0] wb_sel;
  logic [`SMC_DATA_W-1:0]   wb_dat_w, wb_dat_r;
  logic                     wb_ack, wb_err;
  logic [`SMC_ADDR_W-1:0]   mem_addr;
  logic [`SMC_DATA_W/8-1:0] mem_be_n;
  logic [`SMC_DATA_W-1:0]   mem_dq_out, mem_dq_in;
  logic                     mem_dq_oe, mem_cs_n, mem_oe_n, mem_we_n;

  // Vector table
  string       t_name [0:63];
  string       t_op   [0:63];
  string       t_resp [0:63];
  logic [31:0] t_addr [0:63];
  logic [3:0]  t_sel  [0:63];
  logic [31:0] t_data [0:63];
  logic [31:0] t_exp  [0:63];
  int          t_lat  [0:63];
  int          n_tests = 0;
  int          bench_errors = 0;

  logic [31:0] sram [0:65535];

  always #50 pclk = ~pclk;  // 100 ns period

  smc_top smc_top_i (.*);

  smc_checker chk (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .wb_cyc, .wb_stb, .wb_dat_r, .wb_ack, .wb_err,
    .mem_cs_n, .mem_oe_n, .mem_we_n, .mem_dq_oe
  );

  // --------------------
  // SRAM model
  // --------------------
  initial
  begin
    for (int i = 0; i < 65536; i++)
      sram[i] = {i[15:0], ~i[15:0]};  // Unique per address
  end

  always @(posedge mem_we_n)
  begin
    if (rst_n)
    begin
      for (int b = 0; b < 4; b++)
        if (!mem_be_n[b])
          sram[mem_addr][8*b +: 8] = mem_dq_out[8*b +: 8];
    end
  end

  assign mem_dq_in = !mem_oe_n ? sram[mem_addr] : '0;

  // --------------------
  // Bus tasks
  // --------------------
  task apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge pclk) #10;
    psel   = 1;
    pwrite = 1;
    paddr  = addr;
    pwdata = data;
    @(posedge pclk) #10;
    penable = 1;
    @(posedge pclk) #10;  // Taken on that edge
    psel    = 0;
    penable = 0;
  endtask

  task apb_read(input string name, input logic [4:0] addr, input logic [31:0] exp);
    @(posedge pclk) #10;
    psel   = 1;
    pwrite = 0;
    paddr  = addr;
    @(posedge pclk) #10;
    penable = 1;
    @(posedge pclk);
    chk.check_prdata(name, exp);
    #10;
    psel    = 0;
    penable = 0;
  endtask

  task wb_access(input int k, input bit chained);
    int n;
    if (!chained)
      @(posedge pclk) #10;  // Chained requests follow the response directly
    chk.arm_access(t_name[k], t_op[k] == "wb_rd", t_exp[k], t_lat[k], t_resp[k] == "err");
    wb_cyc   = 1;
    wb_stb   = 1;
    wb_we    = (t_op[k] == "wb_wr");
    wb_adr   = t_addr[k][15:0];
    wb_sel   = t_sel[k];
    wb_dat_w = t_data[k];
    n        = 0;
    do
    begin
      @(posedge pclk);
      n++;
    end
    while (!(wb_ack || wb_err) && (n < 40));
    if (n >= 40)
    begin
      $display("%s: no ack or err within 40 cycles", t_name[k]);
      bench_errors++;
    end
    #10;
    wb_cyc = 0;
    wb_stb = 0;
  endtask

  task load_tests;
    int    fd;
    int    rc;
    string line;
    fd = $fopen("smc_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open smc_tests.txt");
      bench_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        if ((rc > 1) && (line.getc(0) != "#"))
        begin
          rc = $sscanf(line, "%s %s %h %h %h %h %d %s", t_name[n_tests], t_op[n_tests],
                       t_addr[n_tests], t_sel[n_tests], t_data[n_tests],
                       t_exp[n_tests], t_lat[n_tests], t_resp[n_tests]);
          if (rc == 8)
            n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Watchdog sized from the test count
  initial
  begin
    wait (n_tests != 0);
    repeat (n_tests * 40) @(posedge pclk);
    $display("Timeout after %0d cycles", n_tests * 40);
    $display("Finished with errors");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    bit chained;
    int total;
    rst_n    = 0;
    psel     = 0;
    penable  = 0;
    pwrite   = 0;
    paddr    = '0;
    pwdata   = '0;
    wb_cyc   = 0;
    wb_stb   = 0;
    wb_we    = 0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    load_tests();
    repeat (2) @(posedge pclk);
    #10 rst_n = 1;
    for (int k = 0; k < n_tests; k++)
    begin
      chained = 0;
      if (k > 0)
        chained = (t_op[k-1] == "wb_wr") || (t_op[k-1] == "wb_rd");  // Back-to-back
      if (t_op[k] == "apb_wr")
        apb_write(t_addr[k][4:0], t_data[k]);
      else if (t_op[k] == "apb_rd")
        apb_read(t_name[k], t_addr[k][4:0], t_exp[k]);
      else
        wb_access(k, chained);
    end
    repeat (4) @(posedge pclk);
    total = chk.errors + bench_errors + smc_top_i.u_fsm.u_props.fails;
    $display("Errors: checker %0d, bench %0d, assertions %0d, total %0d",
             chk.errors, bench_errors, smc_top_i.u_fsm.u_props.fails, total);
    if ((total == 0) && (n_tests > 0))
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- smc_tests.txt
# name op addr sel data exp_data exp_latency resp
# latency -1 means not checked, resp is ack, err or - for APB rows
cfg_rst   apb_rd 00   0 00000000 00000000 -1 -
dis_wr    wb_wr  0001 f 12345678 00000000 0  err
dis_rd    wb_rd  0001 f 00000000 00000000 0  err
cfg_wr    apb_wr 00   0 fffffc21 00000000 -1 -
cfg_rd    apb_rd 00   0 00000000 80000021 -1 -
unmap_rd  apb_rd 04   0 00000000 00000000 -1 -
wr_a      wb_wr  0100 f deadbeef 00000000 4  ack
rd_a      wb_rd  0100 f 00000000 deadbeef 3  ack
wr_b      wb_wr  ffff f 0badf00d 00000000 4  ack
rd_b      wb_rd  ffff f 00000000 0badf00d 3  ack
part_wr   wb_wr  0010 3 aabbccdd 00000000 4  ack
part_rd   wb_rd  0010 f 00000000 0010ccdd 3  ack
part_wr2  wb_wr  0010 8 11223344 00000000 4  ack
part_rd2  wb_rd  0010 f 00000000 1110ccdd 3  ack
cfg2_wr   apb_wr 00   0 80000050 00000000 -1 -
cfg2_rd   apb_rd 00   0 00000000 80000050 -1 -
wr_c      wb_wr  0200 f cafe0001 00000000 7  ack
rd_c      wb_rd  0200 f 00000000 cafe0001 2  ack
cfg3_wr   apb_wr 00   0 80000311 00000000 -1 -
turn_wr   wb_wr  0300 f 01020304 00000000 -1 ack
turn_rd   wb_rd  0300 f 00000000 01020304 -1 ack
turn_rd2  wb_rd  0100 f 00000000 deadbeef -1 ack
cfg_off   apb_wr 00   0 00000000 00000000 -1 -
off_rd    wb_rd  0100 f 00000000 00000000 -1 err

//--- smc_top.f
+incdir+.
smc_pkg.sv
smc_intf.sv
smc_apb_if.sv
smc_wait_timer.sv
smc_fsm.sv
smc_datapath.sv
smc_top.sv
smc_checker.sv
smc_props.sv
smc_tb.sv

//--- Bender.yml
package:
  name: smc

sources:
  - include_dirs:
      - .
    files:
      - smc_pkg.sv
      - smc_intf.sv
      - smc_apb_if.sv
      - smc_wait_timer.sv
      - smc_fsm.sv
      - smc_datapath.sv
      - smc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - smc_checker.sv
      - smc_props.sv
      - smc_tb.sv
